// File: Bender.yml
package:
  name: ctrl_top

sources:
  # RTL in compile order
  - files:
      - src/ctrl_pkg.sv
      - src/ctrl_trap_tracker.sv
      - src/ctrl_main_fsm.sv
      - src/ctrl_top.sv
  # testbench and bound properties
  - target: test
    files:
      - tb/ctrl_top_properties.sv
      - tb/ctrl_top_tb.sv

// File: ctrl_top.f
src/ctrl_pkg.sv
src/ctrl_trap_tracker.sv
src/ctrl_main_fsm.sv
src/ctrl_top.sv
tb/ctrl_top_properties.sv
tb/ctrl_top_tb.sv

// File: src/ctrl_main_fsm.sv
////////////////////////////////////////////////////////////
// main controller FSM, no debug support
// dec_flags_i must stay stable while ID is halted
// all traps go to the single trap vector (PC_EXCEPTION)
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ctrl_main_fsm (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_enable_i,
  input  ctrl_pkg::dec_flags_t dec_flags_i,
  input  logic                 jr_stall_i,
  input  logic                 id_ready_i,
  input  logic                 ex_valid_i,
  input  ctrl_pkg::irq_req_t   irq_i,
  input  ctrl_pkg::trap_kind_e trap_now_i,
  input  ctrl_pkg::trap_kind_e trap_q_i,
  input  ctrl_pkg::cause_t     trap_cause_i,
  output logic                 trap_capture_o,
  output logic                 trap_clear_o,
  output ctrl_pkg::pc_ctrl_t   pc_ctrl_o,
  output ctrl_pkg::csr_ctrl_t  csr_ctrl_o,
  output logic                 irq_ack_o,
  output ctrl_pkg::irq_id_t    irq_id_o,
  output logic                 instr_req_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o,
  output logic                 is_decoding_o,
  output logic                 ctrl_busy_o,
  output logic                 wake_o
);
  import ctrl_pkg::*;

  ctrl_state_e state_q, state_d;

  // one redirect per jump, held until ID moves on
  logic jump_done_q, jump_done_d;

  // set in FIRST_FETCH or DECODE when an interrupt is taken
  logic irq_take;

  ////////////////////////////////////////////////////////////
  // next state and output decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    jump_done_d    = jump_done_q;
    irq_take       = 1'b0;
    trap_capture_o = 1'b0;
    trap_clear_o   = 1'b0;

    pc_ctrl_o.pc_set  = 1'b0;
    pc_ctrl_o.pc_mux  = PC_BOOT;
    csr_ctrl_o.save_if      = 1'b0;
    csr_ctrl_o.save_id      = 1'b0;
    csr_ctrl_o.save_cause   = 1'b0;
    csr_ctrl_o.restore_mret = 1'b0;
    csr_ctrl_o.cause        = '0;

    irq_ack_o     = 1'b0;
    irq_id_o      = '0;
    instr_req_o   = 1'b1;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    is_decoding_o = 1'b0;
    ctrl_busy_o   = 1'b1;

    unique case (state_q)
      // idle until fetch is enabled
      RESET: begin
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address into fetch
      BOOT_SET: begin
        pc_ctrl_o.pc_set = 1'b1;
        pc_ctrl_o.pc_mux = PC_BOOT;
        state_d          = FIRST_FETCH;
      end

      // nothing in ID yet, an interrupt saves the IF pc
      FIRST_FETCH: begin
        state_d = DECODE;
        if (irq_i.req) begin
          irq_take           = 1'b1;
          csr_ctrl_o.save_if = 1'b1;
        end
      end

      DECODE: begin
        if (dec_flags_i.instr_valid) begin
          is_decoding_o = 1'b1;
          if (irq_i.req) begin
            // interrupt wins over everything in ID
            is_decoding_o      = 1'b0;
            irq_take           = 1'b1;
            csr_ctrl_o.save_id = 1'b1;
          end else if (trap_now_i != TRAP_NONE) begin
            // stop fetch, let ID hand the faulting insn to EX
            is_decoding_o  = 1'b0;
            halt_if_o      = 1'b1;
            trap_capture_o = id_ready_i;
            state_d        = id_ready_i ? FLUSH_EX : DECODE;
          end else if (dec_flags_i.jump) begin
            pc_ctrl_o.pc_mux = PC_JUMP;
            // wait out a jump-register stall
            if (!jr_stall_i && !jump_done_q) begin
              pc_ctrl_o.pc_set = 1'b1;
              jump_done_d      = 1'b1;
            end
          end else if (dec_flags_i.mret || dec_flags_i.wfi || dec_flags_i.fencei) begin
            // all three drain the pipe first
            halt_if_o = 1'b1;
            state_d   = id_ready_i ? FLUSH_EX : DECODE;
          end
        end
      end

      // wait for EX to finish, then write mepc and mcause
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
          if (trap_q_i != TRAP_NONE) begin
            csr_ctrl_o.save_id    = 1'b1;
            csr_ctrl_o.save_cause = 1'b1;
            csr_ctrl_o.cause      = trap_cause_i;
          end
        end
      end

      // pipeline empty, act on the held instruction
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        state_d   = DECODE;
        if (trap_q_i != TRAP_NONE) begin
          pc_ctrl_o.pc_set = 1'b1;
          pc_ctrl_o.pc_mux = PC_EXCEPTION;
          trap_clear_o     = 1'b1;
        end else if (dec_flags_i.mret) begin
          csr_ctrl_o.restore_mret = 1'b1;
          state_d                 = XRET_JUMP;
        end else if (dec_flags_i.wfi) begin
          state_d = WAIT_SLEEP;
        end else if (dec_flags_i.fencei) begin
          // refetch the insn after fence.i
          pc_ctrl_o.pc_set = 1'b1;
          pc_ctrl_o.pc_mux = PC_FENCEI;
        end
      end

      // mepc restored last cycle, jump to it now
      XRET_JUMP: begin
        pc_ctrl_o.pc_set = 1'b1;
        pc_ctrl_o.pc_mux = PC_MRET;
        state_d          = DECODE;
      end

      WAIT_SLEEP: begin
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        ctrl_busy_o = 1'b0;
        state_d     = SLEEP;
      end

      // core idle until the interrupt controller wakes us
      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (wake_o) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase

    // common interrupt entry
    if (irq_take) begin
      halt_if_o             = 1'b1;
      halt_id_o             = 1'b1;
      pc_ctrl_o.pc_set      = 1'b1;
      pc_ctrl_o.pc_mux      = PC_EXCEPTION;
      csr_ctrl_o.save_cause = 1'b1;
      csr_ctrl_o.cause      = {1'b1, irq_i.id};
      irq_ack_o             = 1'b1;
      irq_id_o              = irq_i.id;
    end
  end

  ////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // cleared once the jump leaves ID
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

  // any wakeup request ends sleep
  assign wake_o = irq_i.wakeup;

endmodule

// File: src/ctrl_pkg.sv
////////////////////////////////////////////////////////////
// types shared by the controller FSM and the trap tracker
// widths follow the machine-mode trap format and are fixed
////////////////////////////////////////////////////////////

package ctrl_pkg;

  // interrupt line id from the interrupt controller
  typedef logic [4:0] irq_id_t;

  // mcause value, bit 5 marks an interrupt
  typedef logic [5:0] cause_t;

  // synchronous exception codes, low five bits of mcause
  localparam logic [4:0] EXC_CAUSE_INSTR_BUS_FAULT = 5'd1;
  localparam logic [4:0] EXC_CAUSE_ILLEGAL_INSN    = 5'd2;
  localparam logic [4:0] EXC_CAUSE_BREAKPOINT      = 5'd3;
  localparam logic [4:0] EXC_CAUSE_ECALL_MMODE     = 5'd11;

  // next-pc source seen by the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXCEPTION,
    PC_MRET,
    PC_FENCEI
  } pc_mux_e;

  // main controller states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB,
    XRET_JUMP,
    WAIT_SLEEP,
    SLEEP
  } ctrl_state_e;

  // pending synchronous trap
  typedef enum logic [2:0] {
    TRAP_NONE,
    TRAP_BUS_ERR,
    TRAP_ILLEGAL,
    TRAP_EBREAK,
    TRAP_ECALL
  } trap_kind_e;

  // decoder view of the instruction in ID
  typedef struct packed {
    logic instr_valid;
    logic bus_err;
    logic illegal;
    logic ecall;
    logic ebrk;
    logic mret;
    logic wfi;
    logic fencei;
    logic jump;
  } dec_flags_t;

  // fetch redirect, pc_set is a single-cycle strobe
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
  } pc_ctrl_t;

  // csr update commands
  typedef struct packed {
    logic   save_if;
    logic   save_id;
    logic   save_cause;
    logic   restore_mret;
    cause_t cause;
  } csr_ctrl_t;

  // interrupt request bundle
  typedef struct packed {
    logic    req;
    logic    wakeup;
    irq_id_t id;
  } irq_req_t;

endpackage

// File: src/ctrl_top.sv
////////////////////////////////////////////////////////////
// controller top, FSM plus synchronous trap tracker
// no back-pressure on any strobe output
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ctrl_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fetch_enable_i,
  input  ctrl_pkg::dec_flags_t dec_flags_i,
  input  logic                jr_stall_i,
  input  logic                id_ready_i,
  input  logic                ex_valid_i,
  input  ctrl_pkg::irq_req_t  irq_i,
  output ctrl_pkg::pc_ctrl_t  pc_ctrl_o,
  output ctrl_pkg::csr_ctrl_t csr_ctrl_o,
  output logic                irq_ack_o,
  output ctrl_pkg::irq_id_t   irq_id_o,
  output logic                instr_req_o,
  output logic                halt_if_o,
  output logic                halt_id_o,
  output logic                is_decoding_o,
  output logic                ctrl_busy_o,
  output logic                wake_o
);
  import ctrl_pkg::*;

  // tracker to fsm
  trap_kind_e trap_now;
  trap_kind_e trap_q;
  cause_t     trap_cause;

  // fsm to tracker strobes
  logic trap_capture;
  logic trap_clear;

  ctrl_main_fsm fsm_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .dec_flags_i    (dec_flags_i),
    .jr_stall_i     (jr_stall_i),
    .id_ready_i     (id_ready_i),
    .ex_valid_i     (ex_valid_i),
    .irq_i          (irq_i),
    .trap_now_i     (trap_now),
    .trap_q_i       (trap_q),
    .trap_cause_i   (trap_cause),
    .trap_capture_o (trap_capture),
    .trap_clear_o   (trap_clear),
    .pc_ctrl_o      (pc_ctrl_o),
    .csr_ctrl_o     (csr_ctrl_o),
    .irq_ack_o      (irq_ack_o),
    .irq_id_o       (irq_id_o),
    .instr_req_o    (instr_req_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o),
    .is_decoding_o  (is_decoding_o),
    .ctrl_busy_o    (ctrl_busy_o),
    .wake_o         (wake_o)
  );

  ctrl_trap_tracker tracker_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .dec_flags_i    (dec_flags_i),
    .trap_capture_i (trap_capture),
    .trap_clear_i   (trap_clear),
    .trap_now_o     (trap_now),
    .trap_q_o       (trap_q),
    .trap_cause_o   (trap_cause)
  );

endmodule

// File: src/ctrl_trap_tracker.sv
////////////////////////////////////////////////////////////
// synchronous trap tracker
// priority bus error > illegal > ebreak > ecall
// capture and clear must never be strobed together
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ctrl_trap_tracker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  ctrl_pkg::dec_flags_t dec_flags_i,
  input  logic                 trap_capture_i,
  input  logic                 trap_clear_i,
  output ctrl_pkg::trap_kind_e trap_now_o,
  output ctrl_pkg::trap_kind_e trap_q_o,
  output ctrl_pkg::cause_t     trap_cause_o
);
  import ctrl_pkg::*;

  // held kind while the flush runs
  trap_kind_e trap_q;

  // exception code of the held kind
  logic [4:0] trap_code;

  ////////////////////////////////////////////////////////////
  // fault priority for the insn in ID
  ////////////////////////////////////////////////////////////

  always_comb begin
    trap_now_o = TRAP_NONE;
    // flags of an empty ID slot are ignored
    if (dec_flags_i.instr_valid) begin
      if (dec_flags_i.bus_err) begin
        // fetch error, insn bits are garbage
        trap_now_o = TRAP_BUS_ERR;
      end else if (dec_flags_i.illegal) begin
        trap_now_o = TRAP_ILLEGAL;
      end else if (dec_flags_i.ebrk) begin
        trap_now_o = TRAP_EBREAK;
      end else if (dec_flags_i.ecall) begin
        trap_now_o = TRAP_ECALL;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // pending trap register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trap_q <= TRAP_NONE;
    end else if (trap_capture_i) begin
      // sampled on the edge after DECODE commits to the flush
      trap_q <= trap_now_o;
    end else if (trap_clear_i) begin
      // redirect issued, nothing pending anymore
      trap_q <= TRAP_NONE;
    end
  end

  ////////////////////////////////////////////////////////////
  // kind to mcause
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (trap_q)
      TRAP_BUS_ERR: trap_code = EXC_CAUSE_INSTR_BUS_FAULT;
      TRAP_ILLEGAL: trap_code = EXC_CAUSE_ILLEGAL_INSN;
      TRAP_EBREAK:  trap_code = EXC_CAUSE_BREAKPOINT;
      TRAP_ECALL:   trap_code = EXC_CAUSE_ECALL_MMODE;
      // no trap held, code is don't-care for the FSM
      default:      trap_code = '0;
    endcase
  end

  // synchronous causes keep the interrupt bit clear
  assign trap_cause_o = {1'b0, trap_code};
  assign trap_q_o     = trap_q;

endmodule

// File: tb/ctrl_top_properties.sv
////////////////////////////////////////////////////////////
// concurrent checks on the controller strobes
// bound into ctrl_top, reads the FSM state directly
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ctrl_top_properties (
  input logic                  clk,
  input logic                  rst_n,
  input ctrl_pkg::pc_ctrl_t    pc_ctrl_i,
  input ctrl_pkg::csr_ctrl_t   csr_ctrl_i,
  input logic                  irq_ack_i,
  input ctrl_pkg::ctrl_state_e state_i
);
  import ctrl_pkg::*;

  // number of failed assertions so far
  int fail_count = 0;

  ////////////////////////////////////////////////////////////
  // redirects
  ////////////////////////////////////////////////////////////

  // no fetch redirect while idle or asleep
  pc_quiet_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_i == RESET || state_i == SLEEP) |-> !pc_ctrl_i.pc_set
  ) else begin
    $error("pc_set strobe while in RESET or SLEEP");
    fail_count++;
  end

  // trap save in FLUSH_EX, vector jump on the next cycle
  trap_redirect_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_i == FLUSH_EX && csr_ctrl_i.save_cause)
      |=> (pc_ctrl_i.pc_set && pc_ctrl_i.pc_mux == PC_EXCEPTION)
  ) else begin
    $error("no exception redirect after the trap save");
    fail_count++;
  end

  ////////////////////////////////////////////////////////////
  // interrupts
  ////////////////////////////////////////////////////////////

  // ack only with an interrupt cause write
  irq_ack_cause_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    irq_ack_i |-> (csr_ctrl_i.save_cause && csr_ctrl_i.cause[5])
  ) else begin
    $error("irq_ack_o without an interrupt cause save");
    fail_count++;
  end

endmodule

bind ctrl_top ctrl_top_properties props_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .pc_ctrl_i  (pc_ctrl_o),
  .csr_ctrl_i (csr_ctrl_o),
  .irq_ack_i  (irq_ack_o),
  .state_i    (fsm_i.state_q)
);

// File: tb/ctrl_top_tb.sv
////////////////////////////////////////////////////////////
// testbench for the controller top, stops at the first error
// inputs change 2 ns after the rising edge, outputs sampled
// at the falling edge
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ctrl_top_tb;
  import ctrl_pkg::*;

  localparam int RESET_CYCLES   = 10;
  localparam int N_FAULT        = 16;
  localparam int N_IRQ          = 6;
  // boot, faults, interrupts, jump, mret, fence.i, wfi
  localparam int NUM_SEQ        = 1 + N_FAULT + N_IRQ + 4;
  localparam int TIMEOUT_CYCLES = 40 * NUM_SEQ + RESET_CYCLES;

  // what run_flush waits for
  localparam int WAIT_SAVE     = 0;
  localparam int WAIT_RESTORE  = 1;
  localparam int WAIT_REDIRECT = 2;
  localparam int WAIT_IDLE     = 3;

  logic       clk;
  logic       rst_n;
  logic       fetch_enable;
  dec_flags_t dec_flags;
  logic       jr_stall;
  logic       id_ready;
  logic       ex_valid;
  irq_req_t   irq;
  pc_ctrl_t   pc_ctrl;
  csr_ctrl_t  csr_ctrl;
  logic       irq_ack;
  irq_id_t    irq_id;
  logic       instr_req;
  logic       halt_if;
  logic       halt_id;
  logic       is_decoding;
  logic       ctrl_busy;
  logic       wake;

  int   seed;
  int   save_count;
  int   cycles;
  logic redirect_due;

  ctrl_top ctrl_top_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable),
    .dec_flags_i    (dec_flags),
    .jr_stall_i     (jr_stall),
    .id_ready_i     (id_ready),
    .ex_valid_i     (ex_valid),
    .irq_i          (irq),
    .pc_ctrl_o      (pc_ctrl),
    .csr_ctrl_o     (csr_ctrl),
    .irq_ack_o      (irq_ack),
    .irq_id_o       (irq_id),
    .instr_req_o    (instr_req),
    .halt_if_o      (halt_if),
    .halt_id_o      (halt_id),
    .is_decoding_o  (is_decoding),
    .ctrl_busy_o    (ctrl_busy),
    .wake_o         (wake)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reference model and checking
  ////////////////////////////////////////////////////////////

  // mcause from the decoder flags and the interrupt request
  function automatic cause_t expected_cause(input dec_flags_t flags, input irq_req_t req);
    if (req.req) return {1'b1, req.id};
    if (!flags.instr_valid) return '0;
    if (flags.bus_err) return {1'b0, EXC_CAUSE_INSTR_BUS_FAULT};
    if (flags.illegal) return {1'b0, EXC_CAUSE_ILLEGAL_INSN};
    if (flags.ebrk) return {1'b0, EXC_CAUSE_BREAKPOINT};
    if (flags.ecall) return {1'b0, EXC_CAUSE_ECALL_MMODE};
    return '0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // every save_cause strobe is checked here
  always @(negedge clk) begin
    if (rst_n) begin
      // a synchronous trap redirects one cycle after the save
      if (redirect_due) begin
        check_value("pc_ctrl_o.pc_set", pc_ctrl.pc_set, 1);
        check_value("pc_ctrl_o.pc_mux", pc_ctrl.pc_mux, PC_EXCEPTION);
      end
      redirect_due = 1'b0;
      if (irq_ack) begin
        check_value("csr_ctrl_o.save_cause", csr_ctrl.save_cause, 1);
      end
      if (csr_ctrl.save_cause) begin
        save_count = save_count + 1;
        check_value("csr_ctrl_o.cause", csr_ctrl.cause, expected_cause(dec_flags, irq));
        if (irq_ack) begin
          // interrupts redirect in the same cycle
          check_value("irq_id_o", irq_id, irq.id);
          check_value("pc_ctrl_o.pc_set", pc_ctrl.pc_set, 1);
          check_value("pc_ctrl_o.pc_mux", pc_ctrl.pc_mux, PC_EXCEPTION);
        end else begin
          redirect_due = 1'b1;
        end
      end
    end
  end

  // watch the bound property checker
  always @(negedge clk) begin
    if (ctrl_top_i.props_i.fail_count != 0) begin
      $display("a bound assertion on the controller strobes failed at %0t", $time);
      $display("*** TEST FAILED ***");
      $fatal(1, "assertion failure");
    end
  end

  // hard limit on the run length
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  task step();
    @(posedge clk);
    #2;
  endtask

  function automatic logic [4:0] rand_bits();
    int r;
    r = $random(seed);
    return r[4:0];
  endfunction

  // valid insn with a random mix of fault flags
  function automatic dec_flags_t random_faults(input bit force_one);
    dec_flags_t f;
    logic [4:0] r;
    f = '0;
    r = rand_bits();
    f.instr_valid = 1'b1;
    f.bus_err     = r[0];
    f.illegal     = r[1];
    f.ebrk        = r[2];
    f.ecall       = r[3];
    // trap must still win over a jump
    f.jump        = r[4];
    if (force_one && !(f.bus_err || f.illegal || f.ebrk || f.ecall)) f.ecall = 1'b1;
    return f;
  endfunction

  function automatic bit strobe_seen(input int kind);
    case (kind)
      WAIT_SAVE:     return csr_ctrl.save_cause;
      WAIT_RESTORE:  return csr_ctrl.restore_mret;
      WAIT_REDIRECT: return pc_ctrl.pc_set;
      default:       return !ctrl_busy;
    endcase
  endfunction

  // called in the first FLUSH_EX cycle, ex_valid rises after delay cycles
  task automatic run_flush(input int delay, input int kind);
    int n;
    n = 0;
    ex_valid = (delay == 0);
    @(negedge clk);
    while (!strobe_seen(kind)) begin
      step();
      n = n + 1;
      ex_valid = (n >= delay);
      @(negedge clk);
    end
  endtask

  // one DECODE cycle that must stop fetch
  task issue(input dec_flags_t f);
    step();
    dec_flags = f;
    id_ready  = 1'b1;
    @(negedge clk);
    check_value("halt_if_o", halt_if, 1);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequences
  ////////////////////////////////////////////////////////////

  task boot_seq();
    @(negedge clk);
    // outputs in RESET
    check_value("pc_ctrl_o.pc_set", pc_ctrl.pc_set, 0);
    check_value("csr_ctrl_o strobes", {csr_ctrl.save_if, csr_ctrl.save_id,
                csr_ctrl.save_cause, csr_ctrl.restore_mret}, 0);
    check_value("irq_ack_o", irq_ack, 0);
    check_value("instr_req_o", instr_req, 0);
    check_value("halt_if_o/halt_id_o", {halt_if, halt_id}, 0);
    check_value("is_decoding_o", is_decoding, 0);
    check_value("ctrl_busy_o", ctrl_busy, 1);
    step();
    fetch_enable = 1'b1;
    @(negedge clk);
    check_value("pc_ctrl_o.pc_set", pc_ctrl.pc_set, 0);
    step();
    @(negedge clk);
    check_value("pc_ctrl_o.pc_set", pc_ctrl.pc_set, 1);
    check_value("pc_ctrl_o.pc_mux", pc_ctrl.pc_mux, PC_BOOT);
    // interrupt in FIRST_FETCH
    step();
    irq = '{req: 1'b1, wakeup: 1'b0, id: rand_bits()};
    @(negedge clk);
    check_value("irq_ack_o", irq_ack, 1);
    check_value("csr_ctrl_o.save_if", csr_ctrl.save_if, 1);
    step();
    irq = '0;
  endtask

  task jump_seq();
    dec_flags_t f;
    f = '0;
    f.instr_valid = 1'b1;
    f.jump        = 1'b1;
    step();
    dec_flags = f;
    jr_stall  = 1'b1;
    id_ready  = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_value("pc_ctrl_o.pc_set", pc_ctrl.pc_set, 0);
      check_value("is_decoding_o", is_decoding, 1);
      step();
    end
    jr_stall = 1'b0;
    @(negedge clk);
    check_value("pc_ctrl_o.pc_set", pc_ctrl.pc_set, 1);
    check_value("pc_ctrl_o.pc_mux", pc_ctrl.pc_mux, PC_JUMP);
    // jump still in ID, no second redirect
    step();
    @(negedge clk);
    check_value("pc_ctrl_o.pc_set", pc_ctrl.pc_set, 0);
    step();
    id_ready = 1'b1;
    @(negedge clk);
    check_value("pc_ctrl_o.pc_set", pc_ctrl.pc_set, 0);
    step();
    dec_flags = '0;
  endtask

  task fault_seq();
    logic [4:0] r;
    r = rand_bits();
    issue(random_faults(1'b1));
    step();
    run_flush(r[1:0], WAIT_SAVE);
    // still in FLUSH_EX, both stages held
    check_value("halt_id_o", halt_id, 1);
    // FLUSH_WB, the redirect is checked by the compare process
    step();
    ex_valid  = 1'b0;
    dec_flags = '0;
    @(negedge clk);
  endtask

  task irq_decode_seq();
    step();
    dec_flags = random_faults(1'b0);
    irq       = '{req: 1'b1, wakeup: 1'b0, id: rand_bits()};
    @(negedge clk);
    check_value("irq_ack_o", irq_ack, 1);
    check_value("csr_ctrl_o.save_id", csr_ctrl.save_id, 1);
    check_value("csr_ctrl_o.save_if", csr_ctrl.save_if, 0);
    step();
    irq       = '0;
    dec_flags = '0;
  endtask

  task mret_fencei_seq();
    dec_flags_t f;
    f = '0;
    f.instr_valid = 1'b1;
    f.mret        = 1'b1;
    issue(f);
    step();
    run_flush(1, WAIT_RESTORE);
    check_value("pc_ctrl_o.pc_set", pc_ctrl.pc_set, 0);
    step();
    ex_valid  = 1'b0;
    dec_flags = '0;
    @(negedge clk);
    check_value("pc_ctrl_o.pc_set", pc_ctrl.pc_set, 1);
    check_value("pc_ctrl_o.pc_mux", pc_ctrl.pc_mux, PC_MRET);
    f.mret   = 1'b0;
    f.fencei = 1'b1;
    issue(f);
    step();
    run_flush(2, WAIT_REDIRECT);
    check_value("pc_ctrl_o.pc_mux", pc_ctrl.pc_mux, PC_FENCEI);
    step();
    ex_valid  = 1'b0;
    dec_flags = '0;
  endtask

  task wfi_seq();
    dec_flags_t f;
    f = '0;
    f.instr_valid = 1'b1;
    f.wfi         = 1'b1;
    issue(f);
    step();
    run_flush(0, WAIT_IDLE);
    step();
    ex_valid  = 1'b0;
    dec_flags = '0;
    @(negedge clk);
    // now in SLEEP
    check_value("ctrl_busy_o", ctrl_busy, 0);
    check_value("instr_req_o", instr_req, 0);
    check_value("pc_ctrl_o.pc_set", pc_ctrl.pc_set, 0);
    step();
    irq.wakeup = 1'b1;
    @(negedge clk);
    check_value("wake_o", wake, 1);
    check_value("ctrl_busy_o", ctrl_busy, 1);
    // save_if proves the controller is back in FIRST_FETCH
    step();
    irq = '{req: 1'b1, wakeup: 1'b0, id: rand_bits()};
    @(negedge clk);
    check_value("csr_ctrl_o.save_if", csr_ctrl.save_if, 1);
    step();
    irq = '0;
  endtask

  initial begin
    seed         = 32'h34d0d4c5;
    save_count   = 0;
    redirect_due = 1'b0;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    dec_flags    = '0;
    jr_stall     = 1'b0;
    id_ready     = 1'b1;
    ex_valid     = 1'b0;
    irq          = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    boot_seq();
    jump_seq();
    repeat (N_FAULT) fault_seq();
    repeat (N_IRQ) irq_decode_seq();
    mret_fencei_seq();
    wfi_seq();
    step();
    check_value("save_cause count", save_count, N_FAULT + N_IRQ + 2);
    if (ctrl_top_i.props_i.fail_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("%0d bound assertion failures", ctrl_top_i.props_i.fail_count);
      $display("*** TEST FAILED ***");
      $fatal(1, "assertion failure");
    end
  end

endmodule
